// ==== src/epu_settings.svh ====
`ifndef EPU_SETTINGS_SVH
`define EPU_SETTINGS_SVH

// AXI bus widths
`define EPU_DATA_BITS 32
`define EPU_ADDR_BITS 32
`define EPU_ID_BITS   8
`define EPU_LEN_BITS  4

// Input FIFO holds row words
`define EPU_IN_DEPTH  8

// Output FIFO holds two full blocks of result words
`define EPU_OUT_DEPTH 16

// Only response ever returned
`define EPU_RESP_OKAY 2'b00

`endif

// ==== src/epu_pkg.sv ====
`include "epu_settings.svh"

package epu_pkg;

    // Residual sample and transform coefficient
    typedef logic signed [7:0]  sample_t;
    typedef logic signed [15:0] coef_t;

    // Bus word, a row of samples in or a coefficient pair out
    typedef logic [`EPU_DATA_BITS-1:0] word_t;

    typedef logic [`EPU_ID_BITS-1:0]  axi_id_t;
    typedef logic [`EPU_LEN_BITS-1:0] axi_len_t;

    typedef enum logic [1:0] {WR_IDLE, WR_DATA, WR_RESP} wr_state_t;

    typedef enum logic {RD_IDLE, RD_DATA} rd_state_t;

    // Row collection, column pass, result output
    typedef enum logic [1:0] {XF_LOAD, XF_COLUMN, XF_EMIT} xf_state_t;

endpackage

// ==== src/epu_fifo.sv ====
module epu_fifo #(
    parameter type T     = logic [31:0],
    parameter int  DEPTH = 8
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           push,
    input  T                               data_in,
    input  logic                           pop,
    output T                               data_out,
    output logic                           full,
    output logic                           empty,
    output logic [$clog2(DEPTH + 1)-1:0]   count
);

    localparam int PTR_BITS = $clog2(DEPTH);
    localparam int CNT_BITS = $clog2(DEPTH + 1);

    T                    mem [DEPTH];
    logic [PTR_BITS-1:0] wr_ptr;
    logic [PTR_BITS-1:0] rd_ptr;

    function automatic logic [PTR_BITS-1:0] next_ptr(input logic [PTR_BITS-1:0] ptr);
        return (ptr == PTR_BITS'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign data_out = mem[rd_ptr];
    assign full     = (count == CNT_BITS'(DEPTH));
    assign empty    = (count == '0);

    always_ff @(posedge clk)
    begin
        if (push)
        begin
            mem[wr_ptr] <= data_in;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (push)
            begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop)
            begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            // Simultaneous push and pop keeps occupancy
            if (push && !pop)
            begin
                count <= count + 1'b1;
            end
            else if (pop && !push)
            begin
                count <= count - 1'b1;
            end
        end
    end

    a_no_push_full: assert property (@(posedge clk) disable iff (rst) !(push && full));
    a_no_pop_empty: assert property (@(posedge clk) disable iff (rst) !(pop && empty));

endmodule

// ==== src/epu_axi_write.sv ====
`include "epu_settings.svh"

module epu_axi_write (
    input  logic              clk,
    input  logic              rst,
    input  epu_pkg::axi_id_t  awid,
    input  logic              awvalid,
    output logic              awready,
    input  epu_pkg::word_t    wdata,
    input  logic              wlast,
    input  logic              wvalid,
    output logic              wready,
    output epu_pkg::axi_id_t  bid,
    output logic [1:0]        bresp,
    output logic              bvalid,
    input  logic              bready,
    output logic              in_push,
    output epu_pkg::word_t    in_data,
    input  logic              in_full
);

    epu_pkg::wr_state_t state;
    epu_pkg::wr_state_t next_state;
    logic               aw_hs;
    logic               w_hs;

    assign awready = (state == epu_pkg::WR_IDLE) && awvalid;
    // Back-pressure from the input FIFO
    assign wready  = (state == epu_pkg::WR_DATA) && !in_full;
    assign aw_hs   = awvalid && awready;
    assign w_hs    = wvalid && wready;

    // Every accepted beat is one row
    assign in_push = w_hs;
    assign in_data = wdata;
    assign bresp   = `EPU_RESP_OKAY;

    always_comb
    begin
        next_state = state;
        unique case (state)
            epu_pkg::WR_IDLE:
            begin
                if (aw_hs)
                begin
                    next_state = epu_pkg::WR_DATA;
                end
            end
            epu_pkg::WR_DATA:
            begin
                if (w_hs && wlast)
                begin
                    next_state = epu_pkg::WR_RESP;
                end
            end
            default:
            begin
                if (bvalid && bready)
                begin
                    next_state = epu_pkg::WR_IDLE;
                end
            end
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state  <= epu_pkg::WR_IDLE;
            bvalid <= 1'b0;
        end
        else
        begin
            state <= next_state;
            if (w_hs && wlast)
            begin
                bvalid <= 1'b1;
            end
            else if (bready)
            begin
                bvalid <= 1'b0;
            end
        end
    end

    // Id taken on the address handshake itself
    always_ff @(posedge clk)
    begin
        if (aw_hs)
        begin
            bid <= awid;
        end
    end

    // No data beat while a response is still pending
    a_wready_no_resp: assert property (@(posedge clk) disable iff (rst)
        wready |-> !bvalid);

    a_bvalid_hold: assert property (@(posedge clk) disable iff (rst)
        bvalid && !bready |=> bvalid && $stable(bid));

endmodule

// ==== src/epu_transform.sv ====
module epu_transform (
    input  logic            clk,
    input  logic            rst,
    input  logic            in_empty,
    input  epu_pkg::word_t  in_data,
    output logic            in_pop,
    input  logic            out_full,
    output logic            out_push,
    output epu_pkg::word_t  out_data
);

    epu_pkg::xf_state_t state;
    logic [1:0]         row_cnt;
    logic [2:0]         word_idx;
    epu_pkg::coef_t     smp  [4];
    epu_pkg::coef_t     rowt [4][4];
    epu_pkg::coef_t     coef [16];

    // One output of the core matrix applied to a 4-vector
    function automatic epu_pkg::coef_t mrow(
        input logic [1:0]     i,
        input epu_pkg::coef_t a,
        input epu_pkg::coef_t b,
        input epu_pkg::coef_t c,
        input epu_pkg::coef_t d
    );
        epu_pkg::coef_t res;
        unique case (i)
            2'd0: res = a + b + c + d;
            2'd1: res = (a <<< 1) + b - c - (d <<< 1);
            2'd2: res = a - b - c + d;
            default: res = a - (b <<< 1) + (c <<< 1) - d;
        endcase
        return res;
    endfunction

    // Sign extend the four samples of the incoming row
    always_comb
    begin
        for (int c = 0; c < 4; c++)
        begin
            smp[c] = epu_pkg::coef_t'(epu_pkg::sample_t'(in_data[8*c +: 8]));
        end
    end

    assign in_pop   = (state == epu_pkg::XF_LOAD) && !in_empty;
    assign out_push = (state == epu_pkg::XF_EMIT) && !out_full;
    assign out_data = {coef[{word_idx, 1'b1}], coef[{word_idx, 1'b0}]};

    always_ff @(posedge clk)
    begin
        if (in_pop)
        begin
            for (int c = 0; c < 4; c++)
            begin
                rowt[row_cnt][c] <= mrow(2'(c), smp[0], smp[1], smp[2], smp[3]);
            end
        end
        // Column pass over the stored row results
        if (state == epu_pkg::XF_COLUMN)
        begin
            for (int i = 0; i < 4; i++)
            begin
                for (int j = 0; j < 4; j++)
                begin
                    coef[4*i + j] <= mrow(2'(i), rowt[0][j], rowt[1][j], rowt[2][j], rowt[3][j]);
                end
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state    <= epu_pkg::XF_LOAD;
            row_cnt  <= '0;
            word_idx <= '0;
        end
        else
        begin
            unique case (state)
                epu_pkg::XF_LOAD:
                begin
                    if (in_pop)
                    begin
                        row_cnt <= row_cnt + 1'b1;
                        if (row_cnt == 2'd3)
                        begin
                            state <= epu_pkg::XF_COLUMN;
                        end
                    end
                end
                epu_pkg::XF_COLUMN:
                begin
                    state    <= epu_pkg::XF_EMIT;
                    word_idx <= '0;
                end
                default:
                begin
                    if (out_push)
                    begin
                        word_idx <= word_idx + 1'b1;
                        if (word_idx == 3'd7)
                        begin
                            state <= epu_pkg::XF_LOAD;
                        end
                    end
                end
            endcase
        end
    end

    // Next block starts from row 0 once emission is done
    a_emit_rows_clear: assert property (@(posedge clk) disable iff (rst)
        out_push |-> row_cnt == 2'd0);

endmodule

// ==== src/epu_axi_read.sv ====
`include "epu_settings.svh"

module epu_axi_read (
    input  logic                                   clk,
    input  logic                                   rst,
    input  epu_pkg::axi_id_t                       arid,
    input  epu_pkg::axi_len_t                      arlen,
    input  logic                                   arvalid,
    output logic                                   arready,
    output epu_pkg::axi_id_t                       rid,
    output epu_pkg::word_t                         rdata,
    output logic [1:0]                             rresp,
    output logic                                   rlast,
    output logic                                   rvalid,
    input  logic                                   rready,
    input  logic                                   out_empty,
    input  epu_pkg::word_t                         out_data,
    input  logic [$clog2(`EPU_OUT_DEPTH + 1)-1:0]  out_count,
    output logic                                   out_pop,
    output logic                                   interrupt
);

    localparam int CNT_BITS    = $clog2(`EPU_OUT_DEPTH + 1);
    localparam int BLOCK_WORDS = 8;

    epu_pkg::rd_state_t state;
    epu_pkg::axi_len_t  len_r;
    epu_pkg::axi_len_t  beat;
    logic               ar_hs;
    logic               r_hs;

    assign arready = (state == epu_pkg::RD_IDLE) && arvalid;
    assign ar_hs   = arvalid && arready;

    // Data streams straight from the FIFO head
    assign rvalid  = (state == epu_pkg::RD_DATA) && !out_empty;
    assign rdata   = out_data;
    assign rresp   = `EPU_RESP_OKAY;
    assign rlast   = rvalid && (beat == len_r);
    assign r_hs    = rvalid && rready;
    assign out_pop = r_hs;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state     <= epu_pkg::RD_IDLE;
            beat      <= '0;
            interrupt <= 1'b0;
        end
        else
        begin
            // At least one whole block waiting
            interrupt <= (out_count >= CNT_BITS'(BLOCK_WORDS));
            unique case (state)
                epu_pkg::RD_IDLE:
                begin
                    if (ar_hs)
                    begin
                        state <= epu_pkg::RD_DATA;
                        beat  <= '0;
                    end
                end
                default:
                begin
                    if (r_hs)
                    begin
                        beat <= beat + 1'b1;
                        if (rlast)
                        begin
                            state <= epu_pkg::RD_IDLE;
                        end
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (ar_hs)
        begin
            rid   <= arid;
            len_r <= arlen;
        end
    end

    // Burst never runs past its captured length
    a_beat_in_len: assert property (@(posedge clk) disable iff (rst)
        rvalid |-> beat <= len_r);

endmodule

// ==== src/epu_top.sv ====
`include "epu_settings.svh"

module epu_top (
    input  logic                        clk,
    input  logic                        rst,
    input  epu_pkg::axi_id_t            awid,
    input  logic [`EPU_ADDR_BITS-1:0]   awaddr,
    input  epu_pkg::axi_len_t           awlen,
    input  logic [2:0]                  awsize,
    input  logic [1:0]                  awburst,
    input  logic                        awvalid,
    output logic                        awready,
    input  epu_pkg::word_t              wdata,
    input  logic [`EPU_DATA_BITS/8-1:0] wstrb,
    input  logic                        wlast,
    input  logic                        wvalid,
    output logic                        wready,
    output epu_pkg::axi_id_t            bid,
    output logic [1:0]                  bresp,
    output logic                        bvalid,
    input  logic                        bready,
    input  epu_pkg::axi_id_t            arid,
    input  logic [`EPU_ADDR_BITS-1:0]   araddr,
    input  epu_pkg::axi_len_t           arlen,
    input  logic [2:0]                  arsize,
    input  logic [1:0]                  arburst,
    input  logic                        arvalid,
    output logic                        arready,
    output epu_pkg::axi_id_t            rid,
    output epu_pkg::word_t              rdata,
    output logic [1:0]                  rresp,
    output logic                        rlast,
    output logic                        rvalid,
    input  logic                        rready,
    output logic                        interrupt
);

    logic                                  in_push;
    logic                                  in_pop;
    logic                                  in_full;
    logic                                  in_empty;
    epu_pkg::word_t                        in_data;
    epu_pkg::word_t                        in_head;
    logic                                  out_push;
    logic                                  out_pop;
    logic                                  out_full;
    logic                                  out_empty;
    epu_pkg::word_t                        out_data;
    epu_pkg::word_t                        out_head;
    logic [$clog2(`EPU_OUT_DEPTH + 1)-1:0] out_count;

    epu_axi_write i_axi_write (
        .clk     (clk),
        .rst     (rst),
        .awid    (awid),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wlast   (wlast),
        .wvalid  (wvalid),
        .wready  (wready),
        .bid     (bid),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready),
        .in_push (in_push),
        .in_data (in_data),
        .in_full (in_full)
    );

    // Row words waiting for the transform
    epu_fifo #(
        .T     (epu_pkg::word_t),
        .DEPTH (`EPU_IN_DEPTH)
    ) i_in_fifo (
        .clk      (clk),
        .rst      (rst),
        .push     (in_push),
        .data_in  (in_data),
        .pop      (in_pop),
        .data_out (in_head),
        .full     (in_full),
        .empty    (in_empty),
        .count    ()
    );

    epu_transform i_transform (
        .clk      (clk),
        .rst      (rst),
        .in_empty (in_empty),
        .in_data  (in_head),
        .in_pop   (in_pop),
        .out_full (out_full),
        .out_push (out_push),
        .out_data (out_data)
    );

    // Result words waiting for the host
    epu_fifo #(
        .T     (epu_pkg::word_t),
        .DEPTH (`EPU_OUT_DEPTH)
    ) i_out_fifo (
        .clk      (clk),
        .rst      (rst),
        .push     (out_push),
        .data_in  (out_data),
        .pop      (out_pop),
        .data_out (out_head),
        .full     (out_full),
        .empty    (out_empty),
        .count    (out_count)
    );

    epu_axi_read i_axi_read (
        .clk       (clk),
        .rst       (rst),
        .arid      (arid),
        .arlen     (arlen),
        .arvalid   (arvalid),
        .arready   (arready),
        .rid       (rid),
        .rdata     (rdata),
        .rresp     (rresp),
        .rlast     (rlast),
        .rvalid    (rvalid),
        .rready    (rready),
        .out_empty (out_empty),
        .out_data  (out_head),
        .out_count (out_count),
        .out_pop   (out_pop),
        .interrupt (interrupt)
    );

endmodule

// ==== sim/epu_tb_tasks.svh ====
`ifndef EPU_TB_TASKS_SVH
`define EPU_TB_TASKS_SVH

task automatic check_coef(input string name, input epu_pkg::coef_t expected,
                          input epu_pkg::coef_t actual);
    if (actual !== expected)
    begin
        $display("mismatch %s %s expected %0d actual %0d", test_name, name, expected, actual);
        test_errors++;
    end
endtask

task automatic check_id(input string name, input epu_pkg::axi_id_t expected,
                        input epu_pkg::axi_id_t actual);
    if (actual !== expected)
    begin
        $display("mismatch %s %s expected 0x%02h actual 0x%02h", test_name, name, expected,
                 actual);
        test_errors++;
    end
endtask

task automatic check_resp(input string name, input logic [1:0] expected, input logic [1:0] actual);
    if (actual !== expected)
    begin
        $display("mismatch %s %s expected %b actual %b", test_name, name, expected, actual);
        test_errors++;
    end
endtask

task automatic check_level(input string name, input logic expected, input logic actual);
    if (actual !== expected)
    begin
        $display("mismatch %s %s expected %b actual %b", test_name, name, expected, actual);
        test_errors++;
    end
endtask

// Each result word is split into its two coefficients
task automatic check_words(input string name, input epu_pkg::word_t exp [$],
                           input epu_pkg::word_t got [$]);
    if (got.size() != exp.size())
    begin
        $display("%s %s returned %0d words instead of %0d", test_name, name, got.size(),
                 exp.size());
        test_errors++;
    end
    for (int i = 0; i < exp.size() && i < got.size(); i++)
    begin
        check_coef($sformatf("%s coef %0d", name, 2*i), exp[i][15:0], got[i][15:0]);
        check_coef($sformatf("%s coef %0d", name, 2*i+1), exp[i][31:16], got[i][31:16]);
    end
endtask

task automatic check_beats(input string name, input epu_pkg::axi_id_t id, input int len,
                           input epu_pkg::axi_id_t ids [$], input logic [1:0] resps [$],
                           input logic lasts [$]);
    foreach (ids[i])
    begin
        check_id($sformatf("%s rid beat %0d", name, i), id, ids[i]);
        check_resp($sformatf("%s rresp beat %0d", name, i), `EPU_RESP_OKAY, resps[i]);
        check_level($sformatf("%s rlast beat %0d", name, i), i == len, lasts[i]);
    end
endtask

task automatic finish_test(input string name);
    if (test_errors == 0)
    begin
        $display("%s: ok", name);
        tests_passed++;
    end
    else
    begin
        $display("%s: %0d errors", name, test_errors);
        tests_failed++;
    end
    test_errors = 0;
endtask

task automatic single_block_roundtrip();
    epu_pkg::sample_t blk [16];
    epu_pkg::word_t   beats [$];
    epu_pkg::word_t   exp [$];
    epu_pkg::word_t   got [$];
    epu_pkg::axi_id_t ids [$];
    logic [1:0]       resps [$];
    logic             lasts [$];
    epu_pkg::axi_id_t got_bid;
    logic [1:0]       got_bresp;
    test_name = "single block roundtrip";
    check_level("reset interrupt", 1'b0, interrupt);
    check_level("reset bvalid", 1'b0, bvalid);
    check_level("reset rvalid", 1'b0, rvalid);
    check_level("reset wready", 1'b0, wready);
    check_level("reset awready", 1'b0, awready);
    check_level("reset arready", 1'b0, arready);
    random_block(blk);
    pack_rows(blk, beats);
    ref_block(blk, exp);
    axi_write_burst(8'h01, beats, got_bid, got_bresp);
    wait_high(interrupt, "interrupt");
    axi_read_burst(8'h02, 4'd7, 1'b0, got, ids, resps, lasts);
    check_words("single block", exp, got);
    repeat (2) @(posedge clk);
    #1;
    check_level("interrupt after read", 1'b0, interrupt);
    finish_test("single block roundtrip");
endtask

// Impulse top-left, then bottom-right
task automatic impulse_signs();
    epu_pkg::sample_t blk [16];
    epu_pkg::word_t   beats [$];
    epu_pkg::word_t   exp [$];
    epu_pkg::word_t   got [$];
    epu_pkg::axi_id_t ids [$];
    logic [1:0]       resps [$];
    logic             lasts [$];
    epu_pkg::axi_id_t got_bid;
    logic [1:0]       got_bresp;
    test_name = "impulse signs";
    for (int p = 0; p < 2; p++)
    begin
        foreach (blk[i])
        begin
            blk[i] = '0;
        end
        blk[15*p] = (p == 0) ? -8'sd5 : 8'sd3;
        beats = {};
        exp   = {};
        pack_rows(blk, beats);
        ref_block(blk, exp);
        axi_write_burst(8'h10, beats, got_bid, got_bresp);
        wait_high(interrupt, "interrupt");
        axi_read_burst(8'h11, 4'd7, 1'b0, got, ids, resps, lasts);
        if (p == 0)
        begin
            check_coef("impulse dc", epu_pkg::coef_t'(blk[0]), got[0][15:0]);
        end
        check_words($sformatf("impulse %0d", p), exp, got);
    end
    finish_test("impulse signs");
endtask

task automatic id_and_last_echo();
    epu_pkg::sample_t blk [16];
    epu_pkg::word_t   beats [$];
    epu_pkg::word_t   exp [$];
    epu_pkg::word_t   got [$];
    epu_pkg::axi_id_t ids [$];
    logic [1:0]       resps [$];
    logic             lasts [$];
    epu_pkg::axi_id_t got_bid;
    logic [1:0]       got_bresp;
    test_name = "id and last echo";
    random_block(blk);
    pack_rows(blk, beats);
    ref_block(blk, exp);
    axi_write_burst(8'h5a, beats, got_bid, got_bresp);
    check_id("bid", 8'h5a, got_bid);
    check_resp("bresp", `EPU_RESP_OKAY, got_bresp);
    wait_high(interrupt, "interrupt");
    // Block read back as two short bursts
    axi_read_burst(8'ha3, 4'd3, 1'b0, got, ids, resps, lasts);
    check_beats("first half", 8'ha3, 3, ids, resps, lasts);
    check_words("first half", exp[0:3], got);
    axi_read_burst(8'h3c, 4'd3, 1'b0, got, ids, resps, lasts);
    check_beats("second half", 8'h3c, 3, ids, resps, lasts);
    check_words("second half", exp[4:7], got);
    finish_test("id and last echo");
endtask

task automatic two_block_burst();
    epu_pkg::sample_t blk [16];
    epu_pkg::word_t   beats [$];
    epu_pkg::word_t   exp [$];
    epu_pkg::word_t   got [$];
    epu_pkg::axi_id_t ids [$];
    logic [1:0]       resps [$];
    logic             lasts [$];
    epu_pkg::axi_id_t got_bid;
    logic [1:0]       got_bresp;
    test_name = "two block burst";
    for (int b = 0; b < 2; b++)
    begin
        random_block(blk);
        pack_rows(blk, beats);
        ref_block(blk, exp);
    end
    axi_write_burst(8'h22, beats, got_bid, got_bresp);
    check_id("two block bid", 8'h22, got_bid);
    wait_high(interrupt, "interrupt");
    axi_read_burst(8'h23, 4'd15, 1'b0, got, ids, resps, lasts);
    check_beats("two block", 8'h23, 15, ids, resps, lasts);
    check_words("two block", exp, got);
    finish_test("two block burst");
endtask

// Output FIFO fills and the third block waits in the transform
task automatic back_pressure_drain();
    epu_pkg::sample_t blk [16];
    epu_pkg::word_t   beats [$];
    epu_pkg::word_t   exp [$];
    epu_pkg::word_t   got [$];
    epu_pkg::axi_id_t ids [$];
    logic [1:0]       resps [$];
    logic             lasts [$];
    epu_pkg::axi_id_t got_bid;
    logic [1:0]       got_bresp;
    test_name = "back pressure drain";
    for (int b = 0; b < 3; b++)
    begin
        random_block(blk);
        pack_rows(blk, beats);
        ref_block(blk, exp);
    end
    axi_write_burst(8'h77, beats, got_bid, got_bresp);
    check_id("stalled bid", 8'h77, got_bid);
    check_resp("stalled bresp", `EPU_RESP_OKAY, got_bresp);
    wait_high(interrupt, "interrupt");
    for (int b = 0; b < 3; b++)
    begin
        axi_read_burst(epu_pkg::axi_id_t'(8'h80 + b), 4'd7, 1'b1, got, ids, resps, lasts);
        check_beats($sformatf("drain %0d", b), epu_pkg::axi_id_t'(8'h80 + b), 7,
                    ids, resps, lasts);
        check_words($sformatf("drain %0d", b), exp[8*b : 8*b+7], got);
    end
    finish_test("back pressure drain");
endtask

`endif

// ==== sim/epu_tb.sv ====
`include "epu_settings.svh"

module epu_tb;

    localparam int WAIT_LIMIT = 200;

    logic                         clk;
    logic                         rst;
    epu_pkg::axi_id_t             awid;
    logic [`EPU_ADDR_BITS-1:0]    awaddr;
    epu_pkg::axi_len_t            awlen;
    logic [2:0]                   awsize;
    logic [1:0]                   awburst;
    logic                         awvalid;
    logic                         awready;
    epu_pkg::word_t               wdata;
    logic [`EPU_DATA_BITS/8-1:0]  wstrb;
    logic                         wlast;
    logic                         wvalid;
    logic                         wready;
    epu_pkg::axi_id_t             bid;
    logic [1:0]                   bresp;
    logic                         bvalid;
    logic                         bready;
    epu_pkg::axi_id_t             arid;
    logic [`EPU_ADDR_BITS-1:0]    araddr;
    epu_pkg::axi_len_t            arlen;
    logic [2:0]                   arsize;
    logic [1:0]                   arburst;
    logic                         arvalid;
    logic                         arready;
    epu_pkg::axi_id_t             rid;
    epu_pkg::word_t               rdata;
    logic [1:0]                   rresp;
    logic                         rlast;
    logic                         rvalid;
    logic                         rready;
    logic                         interrupt;
    int                           test_errors;
    int                           tests_passed;
    int                           tests_failed;
    string                        test_name;

    epu_top i_dut (
        .clk       (clk),
        .rst       (rst),
        .awid      (awid),
        .awaddr    (awaddr),
        .awlen     (awlen),
        .awsize    (awsize),
        .awburst   (awburst),
        .awvalid   (awvalid),
        .awready   (awready),
        .wdata     (wdata),
        .wstrb     (wstrb),
        .wlast     (wlast),
        .wvalid    (wvalid),
        .wready    (wready),
        .bid       (bid),
        .bresp     (bresp),
        .bvalid    (bvalid),
        .bready    (bready),
        .arid      (arid),
        .araddr    (araddr),
        .arlen     (arlen),
        .arsize    (arsize),
        .arburst   (arburst),
        .arvalid   (arvalid),
        .arready   (arready),
        .rid       (rid),
        .rdata     (rdata),
        .rresp     (rresp),
        .rlast     (rlast),
        .rvalid    (rvalid),
        .rready    (rready),
        .interrupt (interrupt)
    );

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #2 clk = ~clk;
        end
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Verification failed");
        $finish;
    endtask

    // Returns just after the edge where the signal was seen high
    task automatic wait_high(ref logic sig, input string what);
        int n;
        n = 0;
        @(posedge clk);
        while (!sig)
        begin
            n++;
            if (n > WAIT_LIMIT)
            begin
                abort_run($sformatf("timeout, %s never came", what));
            end
            @(posedge clk);
        end
        #1;
    endtask

    task automatic axi_write_burst(input epu_pkg::axi_id_t id, input epu_pkg::word_t beats [$],
                                   output epu_pkg::axi_id_t got_bid, output logic [1:0] got_bresp);
        awid    = id;
        awlen   = epu_pkg::axi_len_t'(beats.size() - 1);
        awvalid = 1'b1;
        wait_high(awready, "awready");
        awvalid = 1'b0;
        foreach (beats[i])
        begin
            wdata  = beats[i];
            wlast  = (i == beats.size() - 1);
            wvalid = 1'b1;
            wait_high(wready, "wready");
        end
        wvalid = 1'b0;
        wlast  = 1'b0;
        bready = 1'b1;
        wait_high(bvalid, "bvalid");
        got_bid   = bid;
        got_bresp = bresp;
        bready    = 1'b0;
    endtask

    task automatic axi_read_burst(input epu_pkg::axi_id_t id, input epu_pkg::axi_len_t len,
                                  input bit stall, output epu_pkg::word_t words [$],
                                  output epu_pkg::axi_id_t ids [$], output logic [1:0] resps [$],
                                  output logic lasts [$]);
        int n;
        words   = {};
        ids     = {};
        resps   = {};
        lasts   = {};
        arid    = id;
        arlen   = len;
        arvalid = 1'b1;
        wait_high(arready, "arready");
        arvalid = 1'b0;
        for (int beat = 0; beat <= int'(len); beat++)
        begin
            n = 0;
            rready = stall ? ($urandom_range(3) != 0) : 1'b1;
            @(posedge clk);
            while (!(rvalid && rready))
            begin
                n++;
                if (n > WAIT_LIMIT)
                begin
                    abort_run($sformatf("timeout, read beat %0d never came", beat));
                end
                #1;
                rready = stall ? ($urandom_range(3) != 0) : 1'b1;
                @(posedge clk);
            end
            words.push_back(rdata);
            ids.push_back(rid);
            resps.push_back(rresp);
            lasts.push_back(rlast);
            #1;
        end
        rready = 1'b0;
    endtask

    task automatic random_block(output epu_pkg::sample_t blk [16]);
        foreach (blk[i])
        begin
            blk[i] = epu_pkg::sample_t'($urandom);
        end
    endtask

    // Row k holds samples 4k to 4k+3, low byte first
    task automatic pack_rows(input epu_pkg::sample_t blk [16], inout epu_pkg::word_t beats [$]);
        for (int k = 0; k < 4; k++)
        begin
            beats.push_back({blk[4*k+3], blk[4*k+2], blk[4*k+1], blk[4*k]});
        end
    endtask

    // Y = M X M^T, rows first, then columns
    task automatic ref_block(input epu_pkg::sample_t blk [16], inout epu_pkg::word_t exp [$]);
        int m [4][4];
        int r [4][4];
        int y [16];
        m = '{'{1, 1, 1, 1}, '{2, 1, -1, -2}, '{1, -1, -1, 1}, '{1, -2, 2, -1}};
        for (int k = 0; k < 4; k++)
        begin
            for (int j = 0; j < 4; j++)
            begin
                r[k][j] = 0;
                for (int l = 0; l < 4; l++)
                begin
                    r[k][j] += m[j][l] * int'(blk[4*k+l]);
                end
            end
        end
        for (int i = 0; i < 4; i++)
        begin
            for (int j = 0; j < 4; j++)
            begin
                y[4*i+j] = 0;
                for (int k = 0; k < 4; k++)
                begin
                    y[4*i+j] += m[i][k] * r[k][j];
                end
            end
        end
        for (int w = 0; w < 8; w++)
        begin
            exp.push_back({16'(y[2*w+1]), 16'(y[2*w])});
        end
    endtask

    `include "epu_tb_tasks.svh"

    initial
    begin
        void'($urandom(96));
        test_errors  = 0;
        tests_passed = 0;
        tests_failed = 0;
        test_name    = "";
        rst          = 1'b1;
        awid         = '0;
        awaddr       = '0;
        awlen        = '0;
        awsize       = 3'd2;
        awburst      = 2'b01;
        awvalid      = 1'b0;
        wdata        = '0;
        wstrb        = '1;
        wlast        = 1'b0;
        wvalid       = 1'b0;
        bready       = 1'b0;
        arid         = '0;
        araddr       = '0;
        arlen        = '0;
        arsize       = 3'd2;
        arburst      = 2'b01;
        arvalid      = 1'b0;
        rready       = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        single_block_roundtrip();
        impulse_signs();
        id_and_last_echo();
        two_block_burst();
        back_pressure_drain();
        $display("tests passed %0d failed %0d", tests_passed, tests_failed);
        if (tests_failed == 0)
        begin
            $display("Verification passed");
        end
        else
        begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// ==== build.f ====
+incdir+src
+incdir+sim
src/epu_pkg.sv
src/epu_fifo.sv
src/epu_axi_write.sv
src/epu_transform.sv
src/epu_axi_read.sv
src/epu_top.sv
sim/epu_tb.sv

// ==== Bender.yml ====
package:
  name: epu

export_include_dirs:
  - src

sources:
  - files:
      - src/epu_pkg.sv
      - src/epu_fifo.sv
      - src/epu_axi_write.sv
      - src/epu_transform.sv
      - src/epu_axi_read.sv
      - src/epu_top.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/epu_tb.sv
